//--- hw/spdif_config.svh
//////////////////////////////////////////////////////////////////////
// receiver constants for cell timing, subframe geometry and blocks
//////////////////////////////////////////////////////////////////////

`ifndef SPDIF_CONFIG_SVH
`define SPDIF_CONFIG_SVH

// oversampling of the line, fixed at 4 clocks per cell
`define SPDIF_CLK_PER_HALF 2
`define SPDIF_CLK_PER_CELL 4

// subframe layout, preamble takes the first 4 cells
`define SPDIF_CELLS_PER_SUBFRAME 32
`define SPDIF_PREAMBLE_HALVES 8

// frames in one channel-status block
`define SPDIF_BLOCK_FRAMES 192

`endif

//--- hw/spdif_frame_pkg.sv
//////////////////////////////////////////////////////////////////////
// line and subframe types: phase, preamble kind, channel, payload
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "spdif_config.svh"

package spdif_frame_pkg;

    typedef logic [$clog2(`SPDIF_CLK_PER_CELL * `SPDIF_CELLS_PER_SUBFRAME)-1:0] phase_t;

    typedef enum logic [1:0] {
        PRE_NONE,
        PRE_B,
        PRE_M,
        PRE_W
    } preamble_t;

    typedef enum logic {
        CH_A,
        CH_B
    } channel_t;

    // cells 4 to 31, first cell at bit 0
    typedef struct packed {
        logic        parity;
        logic        status;
        logic        user;
        logic        validity;
        logic [23:0] sample;
    } wide24_t;

    // 20-bit audio with the aux nibble in the low cells
    typedef struct packed {
        logic        parity;
        logic        status;
        logic        user;
        logic        validity;
        logic [19:0] sample;
        logic [3:0]  aux;
    } aux20_t;

    typedef union packed {
        wide24_t wide24;
        aux20_t  aux20;
    } payload_t;

endpackage

`default_nettype wire

//--- hw/spdif_block_pkg.sv
//////////////////////////////////////////////////////////////////////
// channel-status and user-data block types
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "spdif_config.svh"

package spdif_block_pkg;

    // bit 0 comes from the frame with the B preamble
    typedef logic [`SPDIF_BLOCK_FRAMES-1:0] status_block_t;

    // frames collected so far, 0 while no block is open
    typedef logic [$clog2(`SPDIF_BLOCK_FRAMES + 1)-1:0] frame_count_t;

endpackage

`default_nettype wire

//--- hw/spdif_timing_if.sv
//////////////////////////////////////////////////////////////////////
// subframe phase and strobes shared by timer, lock FSM and decoder
//////////////////////////////////////////////////////////////////////

`default_nettype none

interface spdif_timing_if;
    import spdif_frame_pkg::*;

    phase_t phase;
    logic   half_end;
    logic   cell_end;
    logic   preamble_end;
    logic   payload_end;
    // restart the grid at a line transition
    logic   resync;

    modport timer (
        output phase, half_end, cell_end, preamble_end, payload_end,
        input  resync
    );

    modport fsm (
        input  half_end, cell_end, preamble_end, payload_end,
        output resync
    );

    modport decoder (
        input  phase, half_end, cell_end, preamble_end, payload_end
    );

endinterface

`default_nettype wire

//--- hw/spdif_cell_timer.sv
//////////////////////////////////////////////////////////////////////
// subframe phase counter with resync and half/cell/frame strobes
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "spdif_config.svh"

module spdif_cell_timer (
    input  logic           clk,
    input  logic           rst,
    spdif_timing_if.timer  tim
);
    import spdif_frame_pkg::*;

    localparam int HALF          = `SPDIF_CLK_PER_HALF;
    localparam int CELL          = `SPDIF_CLK_PER_CELL;
    localparam int SUBFRAME_LAST = CELL * `SPDIF_CELLS_PER_SUBFRAME - 1;
    localparam int PREAMBLE_LAST = HALF * `SPDIF_PREAMBLE_HALVES - 1;

    // the clock that saw the transition counts as phase 0
    localparam phase_t RELOAD = phase_t'(1);

    always_ff @(posedge clk) begin
        if (rst) begin
            tim.phase <= '0;
        end else if (tim.resync) begin
            tim.phase <= RELOAD;
        end else if (tim.phase == phase_t'(SUBFRAME_LAST)) begin
            tim.phase <= '0;
        end else begin
            tim.phase <= tim.phase + 1'b1;
        end
    end

    // strobes mark the last clock of each span
    assign tim.half_end     = (tim.phase & phase_t'(HALF - 1)) == phase_t'(HALF - 1);
    assign tim.cell_end     = (tim.phase & phase_t'(CELL - 1)) == phase_t'(CELL - 1);
    assign tim.preamble_end = tim.phase == phase_t'(PREAMBLE_LAST);
    assign tim.payload_end  = tim.phase == phase_t'(SUBFRAME_LAST);

    // free-running grid wraps cleanly after the last payload clock
    a_wrap_after_payload : assert property (
        @(posedge clk) disable iff (rst)
        tim.payload_end && !tim.resync |=> tim.phase == '0
    ) else $error("timer did not wrap to phase 0 after payload_end");

endmodule

`default_nettype wire

//--- hw/spdif_lock_fsm.sv
//////////////////////////////////////////////////////////////////////
// lock FSM: search, preamble check, locked, loss of lock
//////////////////////////////////////////////////////////////////////

`default_nettype none

module spdif_lock_fsm (
    input  logic                       clk,
    input  logic                       rst,
    spdif_timing_if.fsm                tim,
    input  spdif_frame_pkg::preamble_t preamble_kind,
    input  logic                       first_level_steady,
    output logic                       locked
);
    import spdif_frame_pkg::*;

    typedef enum logic [1:0] {
        ST_SEARCH,
        ST_CHECK,
        ST_LOCKED
    } state_t;

    state_t state;

    // move the grid onto any transition seen in the steady window
    assign tim.resync = (state != ST_LOCKED) && !first_level_steady;

    assign locked = state == ST_LOCKED;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_SEARCH;
        end else begin
            case (state)
                ST_SEARCH: begin
                    if (tim.resync) begin
                        state <= ST_CHECK;
                    end else if (tim.preamble_end && preamble_kind != PRE_NONE) begin
                        // grid already sat on a preamble
                        state <= ST_LOCKED;
                    end
                end
                ST_CHECK: begin
                    // grid anchored at a transition, B/M/W all accepted
                    if (tim.preamble_end) begin
                        if (preamble_kind != PRE_NONE) begin
                            state <= ST_LOCKED;
                        end else begin
                            state <= ST_SEARCH;
                        end
                    end
                end
                ST_LOCKED: begin
                    if (tim.preamble_end && preamble_kind == PRE_NONE) begin
                        state <= ST_SEARCH;
                    end
                end
                default: begin
                    state <= ST_SEARCH;
                end
            endcase
        end
    end

    // lock is only ever gained on a classified preamble
    a_lock_on_preamble : assert property (
        @(posedge clk) disable iff (rst)
        $rose(locked) |-> $past(tim.preamble_end)
    ) else $error("locked rose away from preamble_end");

endmodule

`default_nettype wire

//--- hw/spdif_bmc_decoder.sv
//////////////////////////////////////////////////////////////////////
// biphase-mark decoder: preamble classification, payload and parity
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "spdif_config.svh"

module spdif_bmc_decoder (
    input  logic                       clk,
    input  logic                       rst,
    spdif_timing_if.decoder            tim,
    input  logic                       line,
    output logic                       first_level_steady,
    output spdif_frame_pkg::preamble_t preamble_kind,
    output spdif_frame_pkg::payload_t  payload,
    output logic                       payload_valid,
    output spdif_frame_pkg::channel_t  payload_channel,
    output logic                       block_start,
    output logic                       parity_ok
);
    import spdif_frame_pkg::*;

    localparam int HALF          = `SPDIF_CLK_PER_HALF;
    localparam int PRE_BITS      = `SPDIF_PREAMBLE_HALVES;
    localparam int STEADY_LAST   = 3 * HALF - 1;
    localparam int PAYLOAD_FIRST = PRE_BITS * HALF;
    localparam int PAYLOAD_BITS  = $bits(payload_t);

    // half-cell levels, normalised to start high
    localparam logic [PRE_BITS-1:0] PAT_B = 8'b1110_1000;
    localparam logic [PRE_BITS-1:0] PAT_M = 8'b1110_0010;
    localparam logic [PRE_BITS-1:0] PAT_W = 8'b1110_0100;

    logic                    start_lvl;
    logic                    mid_lvl;
    logic [PRE_BITS-2:0]     pre_hist;
    logic [PRE_BITS-1:0]     pre_word;
    logic [PRE_BITS-1:0]     pre_norm;
    logic                    in_window;
    logic                    in_payload;
    logic                    cell_bit;
    logic [PAYLOAD_BITS-1:0] shreg;
    logic [PAYLOAD_BITS-1:0] shreg_next;
    preamble_t               cur_kind;

    // first three half cells of a preamble hold one level
    assign in_window = tim.phase != '0 && tim.phase <= phase_t'(STEADY_LAST);
    assign first_level_steady = !(in_window && line != start_lvl);

    assign pre_word = {pre_hist, line};
    assign pre_norm = pre_word[PRE_BITS-1] ? pre_word : ~pre_word;

    always_comb begin
        case (pre_norm)
            PAT_B:   preamble_kind = PRE_B;
            PAT_M:   preamble_kind = PRE_M;
            PAT_W:   preamble_kind = PRE_W;
            default: preamble_kind = PRE_NONE;
        endcase
    end

    // a one is a level change at mid-cell
    assign in_payload = tim.phase >= phase_t'(PAYLOAD_FIRST);
    assign cell_bit   = line ^ mid_lvl;
    assign shreg_next = {cell_bit, shreg[PAYLOAD_BITS-1:1]};

    always_ff @(posedge clk) begin
        if (tim.phase == '0 || !first_level_steady) begin
            start_lvl <= line;
        end
        if (tim.half_end) begin
            pre_hist <= {pre_hist[PRE_BITS-3:0], line};
        end
        if (tim.half_end && !tim.cell_end) begin
            mid_lvl <= line;
        end
        if (tim.cell_end && in_payload) begin
            shreg <= shreg_next;
        end
        // hold the finished subframe until the next one
        if (tim.payload_end) begin
            payload         <= payload_t'(shreg_next);
            parity_ok       <= ~^shreg_next;
            payload_channel <= (cur_kind == PRE_W) ? CH_B : CH_A;
            block_start     <= cur_kind == PRE_B;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cur_kind      <= PRE_NONE;
            payload_valid <= 1'b0;
        end else begin
            if (tim.preamble_end) begin
                cur_kind <= preamble_kind;
            end
            payload_valid <= tim.payload_end;
        end
    end

    a_valid_after_payload : assert property (
        @(posedge clk) disable iff (rst)
        payload_valid |-> $past(tim.payload_end)
    ) else $error("payload_valid without payload_end");

endmodule

`default_nettype wire

//--- hw/spdif_status_collector.sv
//////////////////////////////////////////////////////////////////////
// channel-status and user-data block collection from channel A
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "spdif_config.svh"

module spdif_status_collector (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           locked,
    input  spdif_frame_pkg::payload_t      payload,
    input  logic                           payload_valid,
    input  spdif_frame_pkg::channel_t      payload_channel,
    input  logic                           block_start,
    output spdif_block_pkg::status_block_t status_block,
    output spdif_block_pkg::status_block_t user_block,
    output logic                           status_valid
);
    import spdif_frame_pkg::*;
    import spdif_block_pkg::*;

    localparam int FRAMES = `SPDIF_BLOCK_FRAMES;

    frame_count_t  frame_count;
    status_block_t c_shift;
    status_block_t u_shift;
    status_block_t c_next;
    status_block_t u_next;
    logic          take;
    logic          block_done;

    assign take = payload_valid && locked && payload_channel == CH_A;

    // newest bit enters at the top so the B frame ends at bit 0
    assign c_next = {payload.wide24.status, c_shift[FRAMES-1:1]};
    assign u_next = {payload.wide24.user, u_shift[FRAMES-1:1]};

    assign block_done = take && !block_start
                        && frame_count == frame_count_t'(FRAMES - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_count  <= '0;
            status_valid <= 1'b0;
        end else begin
            status_valid <= block_done;
            if (!locked) begin
                // partial block lost with the lock
                frame_count <= '0;
            end else if (take) begin
                if (block_start) begin
                    frame_count <= frame_count_t'(1);
                end else if (block_done) begin
                    frame_count <= '0;
                end else if (frame_count != '0) begin
                    frame_count <= frame_count + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            c_shift <= c_next;
            u_shift <= u_next;
        end
        if (block_done) begin
            status_block <= c_next;
            user_block   <= u_next;
        end
    end

endmodule

`default_nettype wire

//--- hw/spdif_rx_top.sv
//////////////////////////////////////////////////////////////////////
// receiver top: timer, lock FSM, decoder and block collector
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "spdif_config.svh"

module spdif_rx_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          line,
    output logic                          locked,
    output logic [23:0]                   sample,
    output logic [3:0]                    aux_nibble,
    output logic                          channel,
    output logic                          validity,
    output logic                          parity_ok,
    output logic                          sample_valid,
    output logic [`SPDIF_BLOCK_FRAMES-1:0] status_block,
    output logic [`SPDIF_BLOCK_FRAMES-1:0] user_block,
    output logic                          status_valid
);
    import spdif_frame_pkg::*;

    preamble_t preamble_kind;
    logic      first_level_steady;
    payload_t  payload;
    logic      payload_valid;
    channel_t  payload_channel;
    logic      block_start;

    spdif_timing_if tim ();

    spdif_cell_timer i_timer (
        .clk (clk),
        .rst (rst),
        .tim (tim.timer)
    );

    spdif_lock_fsm i_lock (
        .clk                (clk),
        .rst                (rst),
        .tim                (tim.fsm),
        .preamble_kind      (preamble_kind),
        .first_level_steady (first_level_steady),
        .locked             (locked)
    );

    spdif_bmc_decoder i_decoder (
        .clk                (clk),
        .rst                (rst),
        .tim                (tim.decoder),
        .line               (line),
        .first_level_steady (first_level_steady),
        .preamble_kind      (preamble_kind),
        .payload            (payload),
        .payload_valid      (payload_valid),
        .payload_channel    (payload_channel),
        .block_start        (block_start),
        .parity_ok          (parity_ok)
    );

    spdif_status_collector i_collector (
        .clk             (clk),
        .rst             (rst),
        .locked          (locked),
        .payload         (payload),
        .payload_valid   (payload_valid),
        .payload_channel (payload_channel),
        .block_start     (block_start),
        .status_block    (status_block),
        .user_block      (user_block),
        .status_valid    (status_valid)
    );

    // same word read as 24-bit audio and as 20-bit audio plus aux
    assign sample       = payload.wide24.sample;
    assign aux_nibble   = payload.aux20.aux;
    assign validity     = payload.wide24.validity;
    assign channel      = payload_channel == CH_B;
    assign sample_valid = payload_valid && locked;

endmodule

`default_nettype wire

//--- verification/spdif_line_driver.sv
//////////////////////////////////////////////////////////////////////
// biphase-mark line model, 2 clocks per half cell
//////////////////////////////////////////////////////////////////////

`default_nettype none

module spdif_line_driver (
    input  wire logic clk,
    output logic      line
);
    timeunit 1ns;
    timeprecision 100ps;

    // preamble half cells when the line was low before
    localparam logic [7:0] PAT_B   = 8'b1110_1000;
    localparam logic [7:0] PAT_M   = 8'b1110_0010;
    localparam logic [7:0] PAT_W   = 8'b1110_0100;
    localparam logic [7:0] PAT_BAD = 8'b1111_0000;

    initial begin
        line = 1'b0;
    end

    // one half cell starting on a falling edge
    task automatic half(input logic lvl);
        line = lvl;
        repeat (2) @(negedge clk);
    endtask

    task automatic hold(input int halves);
        for (int i = 0; i < halves; i++) begin
            half(line);
        end
    endtask

    // idle high so the next stream is the inverse of the one after reset
    task automatic flip_polarity();
        half(1'b1);
    endtask

    // kind 1 is B, 2 is M, 3 is W
    task automatic send_subframe(input logic [1:0] kind, input logic corrupt,
                                 input logic [27:0] bits);
        logic [7:0] pat;
        logic       lvl;
        case (kind)
            2'd1:    pat = PAT_B;
            2'd2:    pat = PAT_M;
            default: pat = PAT_W;
        endcase
        if (corrupt) begin
            pat = PAT_BAD;
        end
        // preamble opens with a transition
        pat = pat ^ {8{line}};
        for (int i = 7; i >= 0; i--) begin
            half(pat[i]);
        end
        for (int i = 0; i < 28; i++) begin
            lvl = ~line;
            half(lvl);
            if (bits[i]) begin
                lvl = ~lvl;
            end
            half(lvl);
        end
    endtask

endmodule

`default_nettype wire

//--- verification/tb_spdif_rx.sv
//////////////////////////////////////////////////////////////////////
// receiver testbench: stimulus, expectation queue, output assertions
//////////////////////////////////////////////////////////////////////

`default_nettype none

module tb_spdif_rx;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [1:0] K_B = 2'd1;
    localparam logic [1:0] K_M = 2'd2;
    localparam logic [1:0] K_W = 2'd3;
    localparam longint LOCK_LIMIT = 3 * 128 * 40 + 80;

    typedef struct packed {
        logic [23:0] sample;
        logic [3:0]  aux;
        logic        chan;
        logic        validity;
        logic        par_ok;
    } expect_t;

    logic clk;
    logic rst;
    wire logic line;
    logic locked;
    logic [23:0] sample;
    logic [3:0] aux_nibble;
    logic channel;
    logic validity;
    logic parity_ok;
    logic sample_valid;
    logic [191:0] status_block;
    logic [191:0] user_block;
    logic status_valid;

    expect_t exp_q[$];
    expect_t head;
    logic have_head;
    logic [31:0] lfsr;
    logic [191:0] blk_c;
    logic [191:0] blk_u;
    logic quiet;
    logic armed;
    logic watch_lock;
    logic locked_d;
    longint send_start;
    int mismatches;
    int failures;
    int status_pulses;

    spdif_rx_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .line         (line),
        .locked       (locked),
        .sample       (sample),
        .aux_nibble   (aux_nibble),
        .channel      (channel),
        .validity     (validity),
        .parity_ok    (parity_ok),
        .sample_valid (sample_valid),
        .status_block (status_block),
        .user_block   (user_block),
        .status_valid (status_valid)
    );

    spdif_line_driver i_drv (
        .clk  (clk),
        .line (line)
    );

    always #20 clk = ~clk;

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    task automatic refresh_head();
        have_head = exp_q.size() != 0;
        head = have_head ? exp_q[0] : '0;
    endtask

    task automatic send_sub(input logic [1:0] kind, input logic flip, input logic corrupt,
                            output logic c, output logic u);
        logic [23:0] smp;
        logic        v;
        logic        p;
        expect_t     e;
        smp = take_bits(24);
        v = take_bits(1) & 1'b1;
        c = take_bits(1) & 1'b1;
        u = take_bits(1) & 1'b1;
        // even parity over cells 4 to 31
        p = ^{c, u, v, smp} ^ flip;
        e.sample = smp;
        e.aux = smp[3:0];
        e.chan = kind == K_W;
        e.validity = v;
        e.par_ok = !flip;
        exp_q.push_back(e);
        refresh_head();
        i_drv.send_subframe(kind, corrupt, {p, c, u, v, smp});
    endtask

    task automatic send_frames(input int n);
        logic c;
        logic u;
        for (int f = 0; f < n; f++) begin
            send_sub(K_M, 1'b0, 1'b0, c, u);
            send_sub(K_W, 1'b0, 1'b0, c, u);
        end
    endtask

    task automatic send_block(input int corrupt_at, input int flip_at);
        logic c;
        logic u;
        logic c_b;
        logic u_b;
        for (int f = 0; f < 192; f++) begin
            if (f == 191 && corrupt_at < 0) begin
                armed = 1'b1;
            end
            send_sub(f == 0 ? K_B : K_M, 1'b0, f == corrupt_at, c, u);
            blk_c[f] = c;
            blk_u[f] = u;
            if (f == corrupt_at && locked) begin
                failures++;
                $display("locked still high after a corrupted preamble");
            end
            send_sub(K_W, f == flip_at, 1'b0, c_b, u_b);
        end
    endtask

    task automatic start_stream();
        send_start = $time;
        watch_lock = 1'b1;
        send_frames(3);
        if (!locked) begin
            failures++;
            $display("no lock after the lead-in frames");
        end
    endtask

    always @(posedge clk) begin
        if (sample_valid && have_head) begin
            exp_q.pop_front();
            refresh_head();
        end
        // samples from before the lock are never delivered
        if (locked && !locked_d) begin
            while (exp_q.size() > 1) begin
                exp_q.pop_front();
            end
            refresh_head();
            if (watch_lock && ($time - send_start) > LOCK_LIMIT) begin
                failures++;
                $display("locked rose later than three subframes after the start");
            end
            watch_lock = 1'b0;
        end
        if (status_valid) begin
            status_pulses++;
            armed = 1'b0;
        end
        locked_d <= locked;
    end

    a_quiet : assert property (@(posedge clk) disable iff (rst)
        quiet |-> !locked && !sample_valid && !status_valid)
        else begin failures++; $display("outputs active on an undriven line"); end

    a_have : assert property (@(posedge clk) disable iff (rst)
        sample_valid |-> have_head)
        else begin failures++; $display("sample_valid with no expected sample"); end

    a_sample : assert property (@(posedge clk) disable iff (rst)
        sample_valid && have_head |-> sample == head.sample)
        else begin
            mismatches++;
            $display("MISMATCH sample got %h exp %h", $sampled(sample), $sampled(head.sample));
        end

    a_aux : assert property (@(posedge clk) disable iff (rst)
        sample_valid && have_head |-> aux_nibble == head.aux)
        else begin
            mismatches++;
            $display("MISMATCH aux_nibble got %h exp %h",
                     $sampled(aux_nibble), $sampled(head.aux));
        end

    a_channel : assert property (@(posedge clk) disable iff (rst)
        sample_valid && have_head |-> channel == head.chan)
        else begin
            mismatches++;
            $display("MISMATCH channel got %h exp %h", $sampled(channel), $sampled(head.chan));
        end

    a_validity : assert property (@(posedge clk) disable iff (rst)
        sample_valid && have_head |-> validity == head.validity)
        else begin
            mismatches++;
            $display("MISMATCH validity got %h exp %h",
                     $sampled(validity), $sampled(head.validity));
        end

    a_parity : assert property (@(posedge clk) disable iff (rst)
        sample_valid && have_head |-> parity_ok == head.par_ok)
        else begin
            mismatches++;
            $display("MISMATCH parity_ok got %h exp %h",
                     $sampled(parity_ok), $sampled(head.par_ok));
        end

    a_status_armed : assert property (@(posedge clk) disable iff (rst)
        status_valid |-> armed)
        else begin failures++; $display("status_valid without a complete block"); end

    a_status_block : assert property (@(posedge clk) disable iff (rst)
        status_valid && armed |-> status_block == blk_c && user_block == blk_u)
        else begin
            mismatches++;
            $display("MISMATCH status_block got %h exp %h",
                     $sampled(status_block), $sampled(blk_c));
            $display("MISMATCH user_block got %h exp %h",
                     $sampled(user_block), $sampled(blk_u));
        end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        lfsr = 32'h8abd4f2a;
        quiet = 1'b0;
        armed = 1'b0;
        watch_lock = 1'b0;
        locked_d = 1'b0;
        send_start = 0;
        mismatches = 0;
        failures = 0;
        status_pulses = 0;
        blk_c = '0;
        blk_u = '0;
        refresh_head();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        quiet = 1'b1;
        i_drv.hold(192);
        quiet = 1'b0;

        // lock, then one clean block with a bad parity on frame 7 channel B
        start_stream();
        send_block(-1, 7);

        // idle line loses lock, then restart inverted
        i_drv.hold(128);
        if (locked) begin
            failures++;
            $display("lock held on an idle line");
        end
        i_drv.flip_polarity();
        start_stream();
        send_frames(6);

        // block broken by a bad preamble at frame 40
        send_block(40, -1);
        send_frames(2);

        for (int t = 0; t < 400 && exp_q.size() != 0; t++) begin
            @(posedge clk);
        end
        if (exp_q.size() != 0) begin
            failures++;
            $display("%0d expected samples never delivered", exp_q.size());
        end
        if (status_pulses != 1) begin
            failures++;
            $display("status_valid pulsed %0d times instead of once", status_pulses);
        end

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+hw
hw/spdif_frame_pkg.sv
hw/spdif_block_pkg.sv
hw/spdif_timing_if.sv
hw/spdif_cell_timer.sv
hw/spdif_lock_fsm.sv
hw/spdif_bmc_decoder.sv
hw/spdif_status_collector.sv
hw/spdif_rx_top.sv
verification/spdif_line_driver.sv
verification/tb_spdif_rx.sv

//--- run_sim.sh
#!/bin/sh
# build and run the receiver testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f --top-module tb_spdif_rx \
    -Mdir obj_dir -o sim_spdif_rx > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/sim_spdif_rx > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL CHECKS PASSED" sim.log; then
    exit 0
fi
exit 1
